/* files.f */
+incdir+include
hw/floor_pkg.sv
hw/request_decode.sv
hw/target_select.sv
hw/motion_result.sv
hw/floor_logic_top.sv
verification/floor_logic_tb.sv

/* Bender.yml */
package:
  name: floor_logic

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/floor_pkg.sv
      - hw/request_decode.sv
      - hw/target_select.sv
      - hw/motion_result.sv
      - hw/floor_logic_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/floor_logic_tb.sv

/* verification/floor_logic_tb.sv */
////////////////////////////////////////////////////////////
// Floor request controller testbench
// Cycle model of lights, target and direction, with
// directed tests and a seeded random run
////////////////////////////////////////////////////////////

`include "elevator_macros.svh"

module floor_logic_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // Directed tests and the random run need about 2000 cycles
    localparam int TIMEOUT_CYCLES = 3000;

    logic clock = 1'b0;
    logic reset_n = 1'b0;
    logic [`NUM_FLOORS-1:0] floor_call_buttons = '0;
    logic [`NUM_FLOORS-1:0] panel_buttons = '0;
    logic door_open_btn = 1'b0;
    logic door_close_btn = 1'b0;
    logic emergency_btn = 1'b0;
    logic power_switch = 1'b1;
    logic [`FLOOR_W-1:0] current_floor = '0;
    logic elevator_moving = 1'b0;
    logic [`FLOOR_W-1:0] elevator_floor_selector;
    logic direction_selector;
    logic activate_elevator;
    logic [`NUM_FLOORS-1:0] call_button_lights;
    logic [`NUM_FLOORS-1:0] panel_button_lights;
    logic door_open_allowed;
    logic door_close_allowed;

    // Model registers, reset values
    logic [`NUM_FLOORS-1:0] model_call = '0;
    logic [`NUM_FLOORS-1:0] model_panel = '0;
    logic [`FLOOR_W-1:0] model_target = '0;
    logic model_dir = 1'b1;

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int test_start_errors = 0;
    int cycle_count = 0;

    floor_logic_top dut_i (.*);

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // Keeps only the lowest set bit
    function automatic logic [`NUM_FLOORS-1:0] lowest_bit(input logic [`NUM_FLOORS-1:0] x);
        return x & (~x + `NUM_FLOORS'(1));
    endfunction

    // Highest lit floor, or the fallback when nothing is lit
    function automatic logic [`FLOOR_W-1:0] highest_floor(
        input logic [`NUM_FLOORS-1:0] lit,
        input logic [`FLOOR_W-1:0]    fallback
    );
        for (int f = `NUM_FLOORS - 1; f >= 0; f--) begin
            if (lit[f]) return `FLOOR_W'(f);
        end
        return fallback;
    endfunction

    task automatic compare_outputs();
        logic exp_act;
        logic exp_open;
        logic exp_close;
        exp_act = power_switch && !emergency_btn && !elevator_moving &&
                  (model_target != current_floor);
        exp_open = door_open_btn && !elevator_moving && power_switch;
        exp_close = door_close_btn && !elevator_moving && power_switch;
        checks++;
        if (call_button_lights !== model_call) begin
            $display("Fail at %0t: call lights %h, expected %h", $time, call_button_lights,
                     model_call);
            errors++;
        end
        if (panel_button_lights !== model_panel) begin
            $display("Fail at %0t: panel lights %h, expected %h", $time, panel_button_lights,
                     model_panel);
            errors++;
        end
        if (elevator_floor_selector !== model_target) begin
            $display("Fail at %0t: target %0d, expected %0d", $time, elevator_floor_selector,
                     model_target);
            errors++;
        end
        if (direction_selector !== model_dir) begin
            $display("Fail at %0t: direction %b, expected %b", $time, direction_selector, model_dir);
            errors++;
        end
        if (activate_elevator !== exp_act) begin
            $display("Fail at %0t: activate %b, expected %b", $time, activate_elevator, exp_act);
            errors++;
        end
        if (door_open_allowed !== exp_open || door_close_allowed !== exp_close) begin
            $display("Fail at %0t: doors %b%b, expected %b%b", $time, door_open_allowed,
                     door_close_allowed, exp_open, exp_close);
            errors++;
        end
    endtask

    // Applies one rising edge to the model, using the inputs seen at that edge
    task automatic update_model();
        logic enable;
        logic [`NUM_FLOORS-1:0] here;
        logic [`NUM_FLOORS-1:0] next_call;
        logic [`NUM_FLOORS-1:0] next_panel;
        enable = power_switch && !emergency_btn;
        here = `NUM_FLOORS'(1) << current_floor;
        next_call = model_call | lowest_bit(floor_call_buttons & ~model_call & ~here);
        next_panel = model_panel | lowest_bit(panel_buttons & ~model_panel & ~here);
        if (!elevator_moving) begin
            next_call = next_call & ~here;
            next_panel = next_panel & ~here;
        end
        if (enable && !elevator_moving && model_target != current_floor) begin
            model_dir = model_target > current_floor;
        end
        if (!elevator_moving && model_target == current_floor) begin
            model_target = highest_floor(model_call | model_panel, current_floor);
        end
        if (enable) begin
            model_call = next_call;
            model_panel = next_panel;
        end
    endtask

    // Called 2 ns after an edge, returns 2 ns after the next one
    task automatic run_cycles(input int n);
        repeat (n) begin
            #16;
            compare_outputs();
            @(posedge clock);
            update_model();
            #2;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("Test %s finished with %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        void'($urandom(79));
        repeat (8) @(posedge clock);
        #2 reset_n = 1'b1;

        // Idle after reset
        run_cycles(3);
        report_test("reset values");

        // Several presses per bank while moving past floor 4
        elevator_moving = 1'b1;
        current_floor = 4'd3;
        floor_call_buttons = 11'b000_1010_1010;
        panel_buttons = 11'b010_0000_1100;
        run_cycles(5);
        if (call_button_lights[3] || panel_button_lights[3]) begin
            $display("Fail at %0t: light set for the current floor", $time);
            errors++;
        end
        report_test("latch priority");

        // Park at the target, then follow targets down the lit floors
        floor_call_buttons = '0;
        panel_buttons = '0;
        elevator_moving = 1'b0;
        current_floor = model_target;
        run_cycles(3);
        for (int k = 0; k < 5; k++) begin
            elevator_moving = 1'b1;
            run_cycles(2);
            current_floor = model_target;
            elevator_moving = 1'b0;
            run_cycles(1);
            if (call_button_lights[current_floor] || panel_button_lights[current_floor]) begin
                $display("Fail at %0t: lights at floor %0d not cleared", $time, current_floor);
                errors++;
            end
            run_cycles(2);
        end
        report_test("arrival and target");

        // Emergency stop, then power off, with presses and door buttons
        emergency_btn = 1'b1;
        floor_call_buttons = '1;
        panel_buttons = '1;
        door_open_btn = 1'b1;
        door_close_btn = 1'b1;
        current_floor = 4'd6;
        run_cycles(3);
        elevator_moving = 1'b1;
        run_cycles(2);
        emergency_btn = 1'b0;
        power_switch = 1'b0;
        elevator_moving = 1'b0;
        run_cycles(3);
        elevator_moving = 1'b1;
        run_cycles(2);
        power_switch = 1'b1;
        report_test("emergency and power off");

        // Random buttons, floors, motion, power and emergency
        for (int c = 0; c < 1500; c++) begin
            floor_call_buttons = `NUM_FLOORS'($urandom_range(0, 2047) &
                                              $urandom_range(0, 2047));
            panel_buttons = `NUM_FLOORS'($urandom_range(0, 2047) & $urandom_range(0, 2047));
            door_open_btn = 1'($urandom_range(0, 1));
            door_close_btn = 1'($urandom_range(0, 1));
            elevator_moving = ($urandom_range(0, 2) == 0);
            power_switch = ($urandom_range(0, 9) != 0);
            emergency_btn = ($urandom_range(0, 9) == 0);
            if ($urandom_range(0, 3) == 0) begin
                current_floor = model_target;
            end else begin
                current_floor = `FLOOR_W'($urandom_range(0, `NUM_FLOORS - 1));
            end
            run_cycles(1);
        end
        report_test("random run");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* hw/floor_logic_top.sv */
////////////////////////////////////////////////////////////
// Floor request controller
// Top level of the eleven floor request controller, joins
// the request, target and motion stages
////////////////////////////////////////////////////////////

`include "elevator_macros.svh"

module floor_logic_top import floor_pkg::*; (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic [`NUM_FLOORS-1:0] floor_call_buttons,
    input  logic [`NUM_FLOORS-1:0] panel_buttons,
    input  logic                   door_open_btn,
    input  logic                   door_close_btn,
    input  logic                   emergency_btn,
    input  logic                   power_switch,
    input  logic [`FLOOR_W-1:0]    current_floor,
    input  logic                   elevator_moving,
    output logic [`FLOOR_W-1:0]    elevator_floor_selector,
    output logic                   direction_selector,
    output logic                   activate_elevator,
    output logic [`NUM_FLOORS-1:0] call_button_lights,
    output logic [`NUM_FLOORS-1:0] panel_button_lights,
    output logic                   door_open_allowed,
    output logic                   door_close_allowed
);

    logic                enable;
    button_req_t         buttons;
    cabin_status_t       status;
    request_lights_t     lights;
    logic [`FLOOR_W-1:0] target_floor;
    motion_cmd_t         cmd;

    // Requests and moves are blocked on emergency or power off
    assign enable = power_switch && !emergency_btn;

    assign buttons = '{call: floor_call_buttons, panel: panel_buttons};
    assign status  = '{current_floor: current_floor, moving: elevator_moving};

    request_decode request_decode_i (
        .clock   (clock),
        .reset_n (reset_n),
        .enable  (enable),
        .buttons (buttons),
        .status  (status),
        .lights  (lights)
    );

    target_select target_select_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .lights       (lights),
        .status       (status),
        .target_floor (target_floor)
    );

    motion_result motion_result_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .enable             (enable),
        .power              (power_switch),
        .target_floor       (target_floor),
        .status             (status),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .cmd                (cmd),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    assign elevator_floor_selector = cmd.target_floor;
    assign direction_selector      = cmd.direction;
    assign activate_elevator       = cmd.activate;
    assign call_button_lights      = lights.call;
    assign panel_button_lights     = lights.panel;

endmodule

/* hw/motion_result.sv */
////////////////////////////////////////////////////////////
// Motion result stage
// Forms the activate and direction command for the elevator
// state machine and gates the door buttons
////////////////////////////////////////////////////////////

`include "elevator_macros.svh"

module motion_result import floor_pkg::*; (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                enable,
    input  logic                power,
    input  logic [`FLOOR_W-1:0] target_floor,
    input  cabin_status_t       status,
    input  logic                door_open_btn,
    input  logic                door_close_btn,
    output motion_cmd_t         cmd,
    output logic                door_open_allowed,
    output logic                door_close_allowed
);

    logic activate;
    logic going_up;
    logic direction;
    logic stopped;

    assign stopped  = !status.moving;
    assign activate = enable && stopped && (target_floor != status.current_floor);
    assign going_up = target_floor > status.current_floor;

    // Direction is only updated while a move is requested
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            direction <= 1'b1;
        end else if (activate) begin
            direction <= going_up;
        end
    end

    always_comb begin
        cmd.target_floor = target_floor;
        cmd.direction    = direction;
        cmd.activate     = activate;
    end

    // Doors respond only to a powered, stopped cabin
    assign door_open_allowed  = door_open_btn && stopped && power;
    assign door_close_allowed = door_close_btn && stopped && power;

    // The target may only move on while the cabin is parked
    target_steady_moving: assert property (
        @(posedge clock) disable iff (!reset_n)
        (target_floor != $past(target_floor)) |-> !$past(status.moving)
    );

endmodule

/* hw/target_select.sv */
////////////////////////////////////////////////////////////
// Target select stage
// Holds the target floor and, once the cabin is parked at
// it, reloads it with the highest lit request
////////////////////////////////////////////////////////////

`include "elevator_macros.svh"

module target_select import floor_pkg::*; (
    input  logic                clock,
    input  logic                reset_n,
    input  request_lights_t     lights,
    input  cabin_status_t       status,
    output logic [`FLOOR_W-1:0] target_floor
);

    logic [`NUM_FLOORS-1:0] any_lit;
    logic [`FLOOR_W-1:0]    next_target;
    logic                   reload;

    // Highest lit floor of either bank, else stay where we are
    always_comb begin
        any_lit     = lights.call | lights.panel;
        next_target = status.current_floor;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (any_lit[i]) begin
                next_target = `FLOOR_W'(i);
            end
        end
    end

    // Only pick a new goal once the old one is reached
    assign reload = !status.moving && (target_floor == status.current_floor);

    //////////////////////////////////////////////////////////
    // Target register
    //////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= '0;
        end else if (reload) begin
            target_floor <= next_target;
        end
    end

    // Lights and current floor both stay inside the shaft, so must the target
    target_in_range: assert property (
        @(posedge clock) disable iff (!reset_n)
        target_floor < `FLOOR_W'(`NUM_FLOORS)
    );

endmodule

/* hw/request_decode.sv */
////////////////////////////////////////////////////////////
// Request decode stage
// Latches hall call and cabin panel presses into request
// lights, one new floor per bank and cycle, and clears the
// lights of the floor where the cabin stands still
////////////////////////////////////////////////////////////

`include "elevator_macros.svh"

module request_decode import floor_pkg::*; (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            enable,
    input  button_req_t     buttons,
    input  cabin_status_t   status,
    output request_lights_t lights
);

    logic [`NUM_FLOORS-1:0] call_set;
    logic [`NUM_FLOORS-1:0] panel_set;
    logic [`NUM_FLOORS-1:0] here_mask;
    logic                   clear_here;

    // One-hot of the lowest pressed floor that is not lit yet
    // and is not the floor the cabin is at
    function automatic logic [`NUM_FLOORS-1:0] lowest_new(
        input logic [`NUM_FLOORS-1:0] pressed,
        input logic [`NUM_FLOORS-1:0] lit,
        input logic [`FLOOR_W-1:0]    here
    );
        logic [`NUM_FLOORS-1:0] pick;
        logic                   found;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (!found && pressed[i] && !lit[i] && (here != `FLOOR_W'(i))) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
        return pick;
    endfunction

    always_comb begin
        call_set   = lowest_new(buttons.call, lights.call, status.current_floor);
        panel_set  = lowest_new(buttons.panel, lights.panel, status.current_floor);
        here_mask  = `NUM_FLOORS'(1) << status.current_floor;
        clear_here = !status.moving;
    end

    //////////////////////////////////////////////////////////
    // Light registers
    //////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else if (enable) begin
            // Set and clear never hit the same bit, the current floor is masked out
            if (clear_here) begin
                lights.call  <= (lights.call | call_set) & ~here_mask;
                lights.panel <= (lights.panel | panel_set) & ~here_mask;
            end else begin
                lights.call  <= lights.call | call_set;
                lights.panel <= lights.panel | panel_set;
            end
        end
    end

    // The state machine only reports real floors
    floor_in_range: assert property (
        @(posedge clock) disable iff (!reset_n)
        status.current_floor < `FLOOR_W'(`NUM_FLOORS)
    );

endmodule

/* hw/floor_pkg.sv */
////////////////////////////////////////////////////////////
// Floor controller types
// Packed structs shared by the request, target and motion
// stages of the floor controller
////////////////////////////////////////////////////////////

`include "elevator_macros.svh"

package floor_pkg;

    // Raw presses of one cycle, bit i stands for floor i+1
    typedef struct packed {
        logic [`NUM_FLOORS-1:0] call;
        logic [`NUM_FLOORS-1:0] panel;
    } button_req_t;

    // Latched requests, same layout as the buttons
    typedef struct packed {
        logic [`NUM_FLOORS-1:0] call;
        logic [`NUM_FLOORS-1:0] panel;
    } request_lights_t;

    // Report from the elevator state machine
    typedef struct packed {
        logic [`FLOOR_W-1:0] current_floor;
        logic                moving;
    } cabin_status_t;

    // Command to the elevator state machine, direction 1 is up
    typedef struct packed {
        logic [`FLOOR_W-1:0] target_floor;
        logic                direction;
        logic                activate;
    } motion_cmd_t;

endpackage

/* include/elevator_macros.svh */
////////////////////////////////////////////////////////////
// Elevator floor controller constants
// Floor count and the width of an encoded floor number
////////////////////////////////////////////////////////////

`ifndef ELEVATOR_MACROS_SVH
`define ELEVATOR_MACROS_SVH

// Floors served, one button and one light per floor and bank
`define NUM_FLOORS 11

// Encoded floor number, floor 1 is 0 and floor 11 is 10
`define FLOOR_W 4

`endif
